// File: common/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// first fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

// number of integer registers, x0 included
`define RV_GPR_COUNT 32

`endif

// File: common/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  // {group, funct3}; group 11 is the branch compares
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLTS = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_EQ   = 5'b11000,
    ALU_NE   = 5'b11001,
    ALU_LTS  = 5'b11100,
    ALU_GES  = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_RS1     = 2'd0,
    OP_A_CURR_PC = 2'd1,
    OP_A_ZERO    = 2'd2
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_RS2   = 3'd0,
    OP_B_IMM_I = 3'd1,
    OP_B_IMM_U = 3'd2,
    OP_B_IMM_S = 3'd3
  } op_b_sel_e;

  // same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_e;

  typedef enum logic {
    WB_EX_RESULT = 1'b0,
    WB_LSU_DATA  = 1'b1
  } wb_sel_e;

endpackage

`default_nettype wire

// File: common/rv_ex_if.sv
`timescale 1ns/100ps
`default_nettype none

// one decoded instruction, held in the ID/EX register
interface rv_ex_if;
  import rv_core_pkg::*;

  logic        valid;
  logic [31:0] pc;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] rs2_data;
  logic [31:0] branch_target;
  logic [4:0]  rd;
  alu_op_e     alu_op;
  logic        gpr_we;
  logic        mem_req;
  logic        mem_we;
  mem_size_e   mem_size;
  wb_sel_e     wb_sel;
  logic        branch;
  logic        illegal;

  modport decode (
    output valid, pc, op_a, op_b, rs2_data, branch_target, rd, alu_op,
           gpr_we, mem_req, mem_we, mem_size, wb_sel, branch, illegal
  );

  modport execute (
    input valid, pc, op_a, op_b, rs2_data, branch_target, rd, alu_op,
          gpr_we, mem_req, mem_we, mem_size, wb_sel, branch, illegal
  );

endinterface

`default_nettype wire

// File: decode/decoder_riscv.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_riscv (
  input  logic [31:0]            fetched_instr_i,
  output rv_core_pkg::op_a_sel_e ex_op_a_sel_o,
  output rv_core_pkg::op_b_sel_e ex_op_b_sel_o,
  output rv_core_pkg::alu_op_e   alu_op_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output rv_core_pkg::mem_size_e mem_size_o,
  output logic                   gpr_we_a_o,
  output rv_core_pkg::wb_sel_e   wb_src_sel_o,
  output logic                   illegal_instr_o,
  output logic                   branch_o
);
  import rv_core_pkg::*;

  localparam logic [6:0] FUNCT7_ZERO = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(fetched_instr_i[6:2]);
  assign funct3 = fetched_instr_i[14:12];
  assign funct7 = fetched_instr_i[31:25];

  always_comb begin
    // defaults: nothing written, nothing requested
    ex_op_a_sel_o   = OP_A_RS1;
    ex_op_b_sel_o   = OP_B_IMM_I;
    alu_op_o        = ALU_ADD;
    mem_req_o       = 1'b0;
    mem_we_o        = 1'b0;
    mem_size_o      = MEM_B;
    gpr_we_a_o      = 1'b0;
    wb_src_sel_o    = WB_EX_RESULT;
    illegal_instr_o = 1'b0;
    branch_o        = 1'b0;

    case (opcode)
      OPC_LOAD: begin
        mem_req_o    = 1'b1;
        mem_size_o   = mem_size_e'(funct3);
        gpr_we_a_o   = 1'b1;
        wb_src_sel_o = WB_LSU_DATA;
        if (!(funct3 inside {MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU})) begin
          illegal_instr_o = 1'b1;
        end
      end

      // fence executes as a no-op
      OPC_MISC_MEM: begin
        wb_src_sel_o = WB_EX_RESULT;
      end

      OPC_OP_IMM: begin
        gpr_we_a_o = 1'b1;
        alu_op_o   = alu_op_e'({2'b00, funct3});
        if (funct3 == 3'b001 && funct7 != FUNCT7_ZERO) begin
          illegal_instr_o = 1'b1;
        end
        // srli / srai share funct3, funct7 bit 5 picks the group
        if (funct3 == 3'b101) begin
          alu_op_o = alu_op_e'({1'b0, funct7[5], funct3});
          if (funct7 != FUNCT7_ZERO && funct7 != FUNCT7_ALT) begin
            illegal_instr_o = 1'b1;
          end
        end
      end

      OPC_AUIPC: begin
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_IMM_U;
        gpr_we_a_o    = 1'b1;
      end

      OPC_STORE: begin
        ex_op_b_sel_o = OP_B_IMM_S;
        mem_req_o     = 1'b1;
        mem_we_o      = 1'b1;
        mem_size_o    = mem_size_e'(funct3);
        if (!(funct3 inside {MEM_B, MEM_H, MEM_W})) begin
          illegal_instr_o = 1'b1;
        end
      end

      OPC_OP: begin
        ex_op_b_sel_o = OP_B_RS2;
        gpr_we_a_o    = 1'b1;
        alu_op_o      = alu_op_e'({1'b0, funct7[5], funct3});
        if (funct7 == FUNCT7_ALT) begin
          // only sub and sra use the alternate funct7
          if (funct3 != 3'b000 && funct3 != 3'b101) begin
            illegal_instr_o = 1'b1;
          end
        end else if (funct7 != FUNCT7_ZERO) begin
          illegal_instr_o = 1'b1;
        end
      end

      OPC_LUI: begin
        ex_op_a_sel_o = OP_A_ZERO;
        ex_op_b_sel_o = OP_B_IMM_U;
        gpr_we_a_o    = 1'b1;
      end

      OPC_BRANCH: begin
        ex_op_b_sel_o = OP_B_RS2;
        alu_op_o      = alu_op_e'({2'b11, funct3});
        branch_o      = 1'b1;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          illegal_instr_o = 1'b1;
          alu_op_o        = ALU_EQ;
        end
      end

      // jal, jalr, system and anything unknown
      default: begin
        illegal_instr_o = 1'b1;
      end
    endcase

    // compressed encodings are not supported
    if (fetched_instr_i[1:0] != 2'b11) begin
      illegal_instr_o = 1'b1;
    end

    if (illegal_instr_o) begin
      mem_req_o  = 1'b0;
      mem_we_o   = 1'b0;
      mem_size_o = MEM_B;
      gpr_we_a_o = 1'b0;
      branch_o   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: decode/rv_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decode_stage (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        if_valid_i,
  input  logic [31:0] if_pc_i,
  input  logic [31:0] if_instr_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_addr_i,
  input  logic [31:0] wb_data_i,
  input  logic        redirect_i,
  rv_ex_if.decode     ex_o
);
  import rv_core_pkg::*;

  logic [31:0] gpr [`RV_GPR_COUNT];

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] op_a;
  logic [31:0] op_b;

  op_a_sel_e   dec_op_a_sel;
  op_b_sel_e   dec_op_b_sel;
  alu_op_e     dec_alu_op;
  logic        dec_mem_req;
  logic        dec_mem_we;
  mem_size_e   dec_mem_size;
  logic        dec_gpr_we;
  wb_sel_e     dec_wb_sel;
  logic        dec_illegal;
  logic        dec_branch;

  // x0 reads zero, a write in flight wins over the array
  function automatic logic [31:0] gpr_read(input logic [4:0]  addr,
                                           input logic [31:0] rf_data,
                                           input logic        we,
                                           input logic [4:0]  waddr,
                                           input logic [31:0] wdata);
    logic [31:0] data;
    if (addr == 5'd0) begin
      data = '0;
    end else if (we && waddr == addr) begin
      data = wdata;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  decoder_riscv u_decoder (
    .fetched_instr_i (if_instr_i),
    .ex_op_a_sel_o   (dec_op_a_sel),
    .ex_op_b_sel_o   (dec_op_b_sel),
    .alu_op_o        (dec_alu_op),
    .mem_req_o       (dec_mem_req),
    .mem_we_o        (dec_mem_we),
    .mem_size_o      (dec_mem_size),
    .gpr_we_a_o      (dec_gpr_we),
    .wb_src_sel_o    (dec_wb_sel),
    .illegal_instr_o (dec_illegal),
    .branch_o        (dec_branch)
  );

  assign rs1 = if_instr_i[19:15];
  assign rs2 = if_instr_i[24:20];
  assign rd  = if_instr_i[11:7];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `RV_GPR_COUNT; i++) begin
        gpr[i] <= '0;
      end
    end else if (wb_we_i && wb_addr_i != 5'd0) begin
      gpr[wb_addr_i] <= wb_data_i;
    end
  end

  assign rs1_data = gpr_read(rs1, gpr[rs1], wb_we_i, wb_addr_i, wb_data_i);
  assign rs2_data = gpr_read(rs2, gpr[rs2], wb_we_i, wb_addr_i, wb_data_i);

  assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
  assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
  assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                  if_instr_i[30:25], if_instr_i[11:8], 1'b0};
  assign imm_u = {if_instr_i[31:12], 12'b0};

  always_comb begin
    case (dec_op_a_sel)
      OP_A_RS1:     op_a = rs1_data;
      OP_A_CURR_PC: op_a = if_pc_i;
      default:      op_a = '0;
    endcase
    case (dec_op_b_sel)
      OP_B_RS2:   op_b = rs2_data;
      OP_B_IMM_I: op_b = imm_i;
      OP_B_IMM_U: op_b = imm_u;
      OP_B_IMM_S: op_b = imm_s;
      default:    op_b = '0;
    endcase
  end

  // ID/EX register
  always_ff @(posedge clk_i) begin
    if (reset_i || redirect_i) begin
      ex_o.valid <= 1'b0;
    end else begin
      ex_o.valid <= if_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_o.pc            <= if_pc_i;
    ex_o.op_a          <= op_a;
    ex_o.op_b          <= op_b;
    ex_o.rs2_data      <= rs2_data;
    ex_o.branch_target <= if_pc_i + imm_b;
    ex_o.rd            <= rd;
    ex_o.alu_op        <= dec_alu_op;
    ex_o.gpr_we        <= dec_gpr_we;
    ex_o.mem_req       <= dec_mem_req;
    ex_o.mem_we        <= dec_mem_we;
    ex_o.mem_size      <= dec_mem_size;
    ex_o.wb_sel        <= dec_wb_sel;
    ex_o.branch        <= dec_branch;
    ex_o.illegal       <= dec_illegal;
  end

endmodule

`default_nettype wire

// File: src/rv_fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_fetch_stage (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  output logic        if_valid_o,
  output logic [31:0] if_pc_o,
  output logic [31:0] if_instr_o
);

  logic [31:0] pc_q;

  // next fetch address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= `RV_RESET_ADDR;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign imem_addr_o = pc_q;

  // IF/ID register, word in flight is dropped on a redirect
  always_ff @(posedge clk_i) begin
    if (reset_i || redirect_i) begin
      if_valid_o <= 1'b0;
    end else begin
      if_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if_pc_o    <= pc_q;
    if_instr_o <= imem_rdata_i;
  end

endmodule

`default_nettype wire

// File: src/rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu (
  input  rv_core_pkg::alu_op_e alu_op_i,
  input  logic [31:0]          a_i,
  input  logic [31:0]          b_i,
  output logic [31:0]          result_o,
  output logic                 flag_o
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       lts;
  logic       ltu;

  assign shamt = b_i[4:0];
  assign lts   = $signed(a_i) < $signed(b_i);
  assign ltu   = a_i < b_i;

  always_comb begin
    result_o = '0;
    flag_o   = 1'b0;
    case (alu_op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLTS: result_o = {31'b0, lts};
      ALU_SLTU: result_o = {31'b0, ltu};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      // branch compares only raise the flag
      ALU_EQ:   flag_o = (a_i == b_i);
      ALU_NE:   flag_o = (a_i != b_i);
      ALU_LTS:  flag_o = lts;
      ALU_GES:  flag_o = !lts;
      ALU_LTU:  flag_o = ltu;
      ALU_GEU:  flag_o = !ltu;
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv_execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute_stage (
  rv_ex_if.execute               ex_i,
  output logic                   redirect_o,
  output logic [31:0]            redirect_pc_o,
  output logic                   wb_we_o,
  output logic [4:0]             wb_addr_o,
  output logic [31:0]            wb_data_o,
  output logic                   dmem_req_o,
  output logic                   dmem_we_o,
  output rv_core_pkg::mem_size_e dmem_size_o,
  output logic [31:0]            dmem_addr_o,
  output logic [31:0]            dmem_wdata_o,
  input  logic [31:0]            dmem_rdata_i,
  output logic                   illegal_instr_o
);
  import rv_core_pkg::*;

  logic [31:0] alu_result;
  logic        alu_flag;
  logic        taken;
  logic [31:0] ld_shifted;
  logic [31:0] ld_data;

  rv_alu u_alu (
    .alu_op_i (ex_i.alu_op),
    .a_i      (ex_i.op_a),
    .b_i      (ex_i.op_b),
    .result_o (alu_result),
    .flag_o   (alu_flag)
  );

  assign taken = ex_i.valid && ex_i.branch && alu_flag;

  // next pc of this instruction, only used by fetch when taken
  assign redirect_o    = taken;
  assign redirect_pc_o = taken ? ex_i.branch_target : ex_i.pc + 32'd4;

  assign dmem_req_o   = ex_i.valid && ex_i.mem_req;
  assign dmem_we_o    = ex_i.valid && ex_i.mem_we;
  assign dmem_size_o  = ex_i.valid ? ex_i.mem_size : MEM_B;
  assign dmem_addr_o  = {32{ex_i.valid}} & alu_result;
  assign dmem_wdata_o = {32{ex_i.valid}} & ex_i.rs2_data;

  assign illegal_instr_o = ex_i.valid && ex_i.illegal;

  // memory returns the aligned word, bring the addressed bytes down
  assign ld_shifted = dmem_rdata_i >> {alu_result[1:0], 3'b000};

  always_comb begin
    case (ex_i.mem_size)
      MEM_B:   ld_data = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
      MEM_H:   ld_data = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
      MEM_BU:  ld_data = {24'b0, ld_shifted[7:0]};
      MEM_HU:  ld_data = {16'b0, ld_shifted[15:0]};
      default: ld_data = dmem_rdata_i;
    endcase
  end

  assign wb_we_o   = ex_i.valid && ex_i.gpr_we;
  assign wb_addr_o = {5{ex_i.valid}} & ex_i.rd;
  assign wb_data_o = (ex_i.wb_sel == WB_LSU_DATA) ? ld_data : alu_result;

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_rdata_i,
  output logic        dmem_req_o,
  output logic        dmem_we_o,
  output logic [2:0]  dmem_size_o,
  output logic [31:0] dmem_addr_o,
  output logic [31:0] dmem_wdata_o,
  input  logic [31:0] dmem_rdata_i,
  output logic        illegal_instr_o
);

  logic        if_valid;
  logic [31:0] if_pc;
  logic [31:0] if_instr;
  logic        wb_we;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        redirect;
  logic [31:0] redirect_pc;

  rv_ex_if u_ex_if ();

  rv_fetch_stage u_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .if_valid_o    (if_valid),
    .if_pc_o       (if_pc),
    .if_instr_o    (if_instr)
  );

  rv_decode_stage u_decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .if_valid_i (if_valid),
    .if_pc_i    (if_pc),
    .if_instr_i (if_instr),
    .wb_we_i    (wb_we),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data),
    .redirect_i (redirect),
    .ex_o       (u_ex_if.decode)
  );

  rv_execute_stage u_execute (
    .ex_i            (u_ex_if.execute),
    .redirect_o      (redirect),
    .redirect_pc_o   (redirect_pc),
    .wb_we_o         (wb_we),
    .wb_addr_o       (wb_addr),
    .wb_data_o       (wb_data),
    .dmem_req_o      (dmem_req_o),
    .dmem_we_o       (dmem_we_o),
    .dmem_size_o     (dmem_size_o),
    .dmem_addr_o     (dmem_addr_o),
    .dmem_wdata_o    (dmem_wdata_o),
    .dmem_rdata_i    (dmem_rdata_i),
    .illegal_instr_o (illegal_instr_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic reset_o
);

  int   rst_cnt = 10;
  logic req_q = 1'b0;

  initial begin
    clk_o = 1'b0;
  end

  always #5 clk_o = ~clk_o;

  // request seen at the rising edge, reset moves on the falling edge
  always @(posedge clk_o) begin
    req_q <= rst_req_i;
  end

  always @(negedge clk_o) begin
    if (req_q) begin
      rst_cnt <= 10;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign reset_o = (rst_cnt != 0);

endmodule

`default_nettype wire

// File: sim/rv_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] imem_addr_i,
  input  logic        dmem_req_i,
  input  logic        dmem_we_i,
  input  logic [2:0]  dmem_size_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic        illegal_i
);

  // expected events in program order, kind 0 is a store and kind 1 an illegal word
  logic        exp_kind [$];
  logic [31:0] exp_addr [$];
  logic [2:0]  exp_size [$];
  logic [31:0] exp_data [$];

  int   value_errors = 0;
  int   missing_events = 0;
  int   extra_events = 0;
  logic rst_q = 1'b1;

  task automatic add_expected(input logic kind, input logic [31:0] addr,
                              input logic [2:0] size, input logic [31:0] data);
    exp_kind.push_back(kind);
    exp_addr.push_back(addr);
    exp_size.push_back(size);
    exp_data.push_back(data);
  endtask

  task automatic end_program();
    if (exp_kind.size() != 0) begin
      $display("%0t: program ended with %0d expected events never seen",
               $time, exp_kind.size());
      missing_events += exp_kind.size();
    end
    exp_kind.delete();
    exp_addr.delete();
    exp_size.delete();
    exp_data.delete();
  endtask

  task automatic take_event(input logic kind, input logic [31:0] addr,
                            input logic [2:0] size, input logic [31:0] data);
    logic ok;
    if (exp_kind.size() == 0) begin
      $display("%0t: the core made an event that the model did not expect", $time);
      extra_events++;
    end else begin
      ok = (exp_kind[0] == kind);
      if (ok && kind == 1'b0) begin
        ok = exp_addr[0] == addr && exp_size[0] == size && exp_data[0] == data;
      end
      if (!ok) begin
        $display("Fail %0t: expected kind %0d addr %h size %0d data %h, got %0d %h %0d %h",
                 $time, exp_kind[0], exp_addr[0], exp_size[0], exp_data[0],
                 kind, addr, size, data);
        value_errors++;
      end
      void'(exp_kind.pop_front());
      void'(exp_addr.pop_front());
      void'(exp_size.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  always @(posedge clk_i) begin
    rst_q <= reset_i;
  end

  // outputs settle after the rising edge, sample them at the falling one
  always @(negedge clk_i) begin
    if (rst_q) begin
      if (dmem_req_i !== 1'b0 || illegal_i !== 1'b0) begin
        $display("Fail %0t: memory request or illegal flag active in reset", $time);
        value_errors++;
      end
      if (imem_addr_i !== `RV_RESET_ADDR) begin
        $display("Fail %0t: fetch address %h in reset", $time, imem_addr_i);
        value_errors++;
      end
    end else begin
      if (dmem_req_i && dmem_we_i) begin
        take_event(1'b0, dmem_addr_i, dmem_size_i, dmem_wdata_i);
      end
      if (illegal_i) begin
        take_event(1'b1, '0, '0, '0);
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

  localparam int NUM_PROGS      = 20;
  localparam int RAND_LEN       = 64;
  localparam int END_IDX        = RAND_LEN + 31;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (3 * (END_IDX + 1) + 20);
  localparam logic [31:0] NOP   = 32'h0000_0013;

  logic        clk;
  logic        reset;
  logic        rst_req;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic        dmem_req;
  logic        dmem_we;
  logic [2:0]  dmem_size;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        illegal;

  logic [31:0] imem [128];
  logic [31:0] dmem [64];
  integer      seed;
  int          cycles = 0;
  int          hits;

  tb_clock_gen u_clk (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .reset_o   (reset)
  );

  rv_core_top u_rv_core_top (
    .clk_i           (clk),
    .reset_i         (reset),
    .imem_addr_o     (imem_addr),
    .imem_rdata_i    (imem_rdata),
    .dmem_req_o      (dmem_req),
    .dmem_we_o       (dmem_we),
    .dmem_size_o     (dmem_size),
    .dmem_addr_o     (dmem_addr),
    .dmem_wdata_o    (dmem_wdata),
    .dmem_rdata_i    (dmem_rdata),
    .illegal_instr_o (illegal)
  );

  rv_core_checker u_checker (
    .clk_i        (clk),
    .reset_i      (reset),
    .imem_addr_i  (imem_addr),
    .dmem_req_i   (dmem_req),
    .dmem_we_i    (dmem_we),
    .dmem_size_i  (dmem_size),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .illegal_i    (illegal)
  );

  // start contents of the data memory, from the whole word address
  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] a;
    a = 8'(idx);
    return (32'h9e37_79b9 * (32'(idx) + 32'd1)) ^ {a, ~a, a, ~a};
  endfunction

  function automatic int rnd(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  // OP and OP-IMM results, alt selects sub and sra
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] load_extend(input logic [31:0] word, input logic [1:0] lo,
                                              input logic [2:0] f3);
    logic [31:0] sh;
    sh = word >> {lo, 3'b000};
    case (f3)
      3'd0: return {{24{sh[7]}}, sh[7:0]};
      3'd1: return {{16{sh[15]}}, sh[15:0]};
      3'd4: return {24'b0, sh[7:0]};
      3'd5: return {16'b0, sh[15:0]};
      default: return word;
    endcase
  endfunction

  // little endian byte lanes of one store
  function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [1:0] lo,
                                              input logic [2:0] f3, input logic [31:0] data);
    logic [31:0] mask;
    case (f3[1:0])
      2'd0: mask = 32'h0000_00ff << {lo, 3'b000};
      2'd1: mask = 32'h0000_ffff << {lo, 3'b000};
      default: mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | ((data << {lo, 3'b000}) & mask);
  endfunction

  task automatic build_program();
    int          sel;
    int          skip;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] word;
    for (int k = 0; k < 128; k++) begin
      imem[k] = NOP;
    end
    for (int k = 0; k < RAND_LEN; k++) begin
      sel  = rnd(16);
      rd   = 5'(rnd(16));
      rs1  = 5'(rnd(16));
      rs2  = 5'(rnd(16));
      f3   = 3'(rnd(8));
      word = $random(seed);
      if (sel < 4) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? 7'h20 : 7'h00;
        imem[k] = {f7, rs2, rs1, f3, rd, 7'h33};
      end else if (sel < 7) begin
        imm = word[11:0];
        if (f3 == 3'd1) begin
          imm = {7'h00, word[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {word[10] ? 7'h20 : 7'h00, word[4:0]};
        end
        imem[k] = {imm, rs1, f3, rd, 7'h13};
      end else if (sel == 7) begin
        imem[k] = {word[31:12], rd, 7'h37};
      end else if (sel == 8) begin
        imem[k] = {word[31:12], rd, 7'h17};
      end else if (sel == 9) begin
        imem[k] = 32'h0ff0_000f;
      end else if (sel < 12) begin
        // x0 based, so the offset is the address, aligned to the size
        f3 = 3'(rnd(5));
        if (f3 >= 3'd3) begin
          f3 = f3 + 3'd1;
        end
        imm = {4'h0, word[7:0] & ~((8'd1 << f3[1:0]) - 8'd1)};
        imem[k] = {imm, 5'd0, f3, rd, 7'h03};
      end else if (sel < 14) begin
        f3 = 3'(rnd(3));
        imm = {4'h0, word[7:0] & ~((8'd1 << f3[1:0]) - 8'd1)};
        imem[k] = enc_s(imm, rs2, 5'd0, f3);
      end else if (sel == 14) begin
        if (f3 == 3'd2 || f3 == 3'd3) begin
          f3 = 3'd0;
        end
        // forward only, never past the register dump
        skip = 1 + rnd(4);
        if (k + skip > RAND_LEN) begin
          skip = RAND_LEN - k;
        end
        imem[k] = enc_b(13'(skip * 4), rs2, rs1, f3);
      end else begin
        case (rnd(3))
          0: imem[k] = {word[31:2], 2'(rnd(3))};
          1: imem[k] = {word[31:7], 7'h6f};
          default: imem[k] = {word[31:7], 7'h73};
        endcase
      end
    end
    for (int r = 1; r < 32; r++) begin
      imem[RAND_LEN + r - 1] = enc_s(12'(128 + 4 * (r - 1)), 5'(r), 5'd0, 3'b010);
    end
    imem[END_IDX] = enc_b(13'd0, 5'd0, 5'd0, 3'd0);
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
  endtask

  // in-order ISA model, hands every store and illegal word to the checker
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [2:0]  f3;
    logic        wr;
    int          idx;
    int          next;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
    idx = 0;
    while (idx < END_IDX) begin
      instr = imem[idx];
      pc    = `RV_RESET_ADDR + 32'(idx * 4);
      f3    = instr[14:12];
      a     = regs[instr[19:15]];
      b     = regs[instr[24:20]];
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u = {instr[31:12], 12'h000};
      res   = '0;
      wr    = 1'b0;
      next  = idx + 1;
      case (instr[6:0])
        7'h33: begin
          res = alu_model(f3, instr[30], a, b);
          wr  = 1'b1;
        end
        7'h13: begin
          res = alu_model(f3, f3 == 3'd5 && instr[30], a, imm_i);
          wr  = 1'b1;
        end
        7'h37: begin
          res = imm_u;
          wr  = 1'b1;
        end
        7'h17: begin
          res = pc + imm_u;
          wr  = 1'b1;
        end
        7'h0f: begin
          wr = 1'b0;
        end
        7'h03: begin
          addr = a + imm_i;
          res  = load_extend(mem[addr[7:2]], addr[1:0], f3);
          wr   = 1'b1;
        end
        7'h23: begin
          addr = a + imm_s;
          mem[addr[7:2]] = store_merge(mem[addr[7:2]], addr[1:0], f3, b);
          u_checker.add_expected(1'b0, addr, f3, b);
        end
        7'h63: begin
          if (branch_taken(f3, a, b)) begin
            next = idx + int'($signed(imm_b) >>> 2);
          end
        end
        default: begin
          u_checker.add_expected(1'b1, '0, '0, '0);
        end
      endcase
      if (wr && instr[11:7] != 5'd0) begin
        regs[instr[11:7]] = res;
      end
      idx = next;
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d wrong values, %0d missing events, %0d extra events",
             u_checker.value_errors, u_checker.missing_events, u_checker.extra_events);
  endtask

  // combinational-read memories, refreshed on the falling edge
  always @(negedge clk) begin
    if (dmem_req && dmem_we) begin
      dmem[dmem_addr[7:2]] = store_merge(dmem[dmem_addr[7:2]], dmem_addr[1:0],
                                         dmem_size, dmem_wdata);
    end
    dmem_rdata <= dmem[dmem_addr[7:2]];
    imem_rdata <= imem[7'((imem_addr - `RV_RESET_ADDR) >> 2)];
  end

  always @(negedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_counts();
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    seed       = 32'h40a1_f927;
    rst_req    = 1'b0;
    imem_rdata = NOP;
    dmem_rdata = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      @(negedge clk);
      rst_req = 1'b1;
      @(negedge clk);
      rst_req = 1'b0;
      @(negedge clk);
      build_program();
      run_model();
      // done once the final branch is fetched a second time, by its own redirect
      hits = 0;
      while (hits < 2) begin
        @(negedge clk);
        if (imem_addr == `RV_RESET_ADDR + 32'(END_IDX * 4)) begin
          hits++;
        end
      end
      repeat (4) @(negedge clk);
      u_checker.end_program();
    end
    report_counts();
    if (u_checker.value_errors + u_checker.missing_events + u_checker.extra_events == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+common
common/rv_core_pkg.sv
common/rv_ex_if.sv
decode/decoder_riscv.sv
decode/rv_decode_stage.sv
src/rv_fetch_stage.sv
src/rv_alu.sv
src/rv_execute_stage.sv
src/rv_core_top.sv
sim/tb_clock_gen.sv
sim/rv_core_checker.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rv_core \
  -Mdir obj_dir -f rv_core.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
